// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds with Verilator, runs, and passes only if the pass line appears in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cell_array_tb \
    -f verilog.f -o cell_array_sim &&
./obj_dir/cell_array_sim | tee /dev/stderr | grep -qx "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== source/array_sequencer.sv ====
// orders bias, program, read-back and read steps; waits without limit on cell_written
`timescale 1ns/1ps
`include "cell_array_settings.svh"

module array_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  cell_array_pkg::opcode_t   op,
    input  logic                      cell_written,
    input  cell_array_pkg::word_t     word,
    output cell_array_pkg::line_cmd_t line_cmd,
    output cell_array_pkg::row_t      row,
    output logic                      sample,
    output logic                      read_active,
    output logic                      done
);
    import cell_array_pkg::*;

    seq_state_t state;
    logic       last_row;

    assign last_row = (row == row_t'(`CELL_ROWS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            row <= '0;
            read_active <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        row <= '0;
                        read_active <= 1'b0;
                        if (op == op_write) begin
                            state <= st_wln_all_mid;
                        end else begin
                            state <= st_read_bias;
                        end
                    end
                end
                // write bias sequence
                st_wln_all_mid: state <= st_bias_unsel;
                st_bias_unsel: state <= st_wln_all_gnd;
                st_wln_all_gnd: state <= st_pl_sel_high;
                st_pl_sel_high: state <= st_prg_write;
                st_prg_write: state <= st_scan;
                // one bit per cycle, zeros are skipped
                st_scan: begin
                    if (word[row]) begin
                        state <= st_wlp_high;
                    end else if (last_row) begin
                        state <= st_sel_off;
                    end else begin
                        row <= row + 1'b1;
                    end
                end
                st_wlp_high: state <= st_wln_mid;
                st_wln_mid: state <= st_wait_written;
                st_wait_written: begin
                    if (cell_written) begin
                        state <= st_wln_gnd;
                    end
                end
                st_wln_gnd: state <= st_wlp_mid;
                st_wlp_mid: begin
                    if (last_row) begin
                        state <= st_sel_off;
                    end else begin
                        row <= row + 1'b1;
                        state <= st_scan;
                    end
                end
                st_sel_off: state <= st_all_off;
                st_all_off: begin
                    row <= '0;
                    state <= st_read_bias;
                end
                // read pass, shared by read and verify
                st_read_bias: state <= st_read_wln;
                st_read_wln: state <= st_read_sample;
                st_read_sample: state <= st_read_wln_gnd;
                st_read_wln_gnd: begin
                    if (last_row) begin
                        state <= st_read_off;
                    end else begin
                        row <= row + 1'b1;
                        state <= st_read_wln;
                    end
                end
                st_read_off: state <= st_compare;
                st_compare: begin
                    read_active <= (op == op_read);
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // line commands decoded from the current step
    always_comb begin
        line_cmd = lc_none;
        sample = 1'b0;
        done = 1'b0;
        case (state)
            st_wln_all_mid: line_cmd = lc_wln_all_mid;
            st_bias_unsel: line_cmd = lc_bias_unselected;
            st_wln_all_gnd: line_cmd = lc_wln_all_gnd;
            st_pl_sel_high: line_cmd = lc_pl_sel_high;
            st_wlp_high: line_cmd = lc_wlp_row_high;
            st_wln_mid: line_cmd = lc_wln_row_mid;
            st_wln_gnd: line_cmd = lc_wln_row_gnd;
            st_wlp_mid: line_cmd = lc_wlp_row_mid;
            st_sel_off: line_cmd = lc_sel_off;
            st_all_off: line_cmd = lc_all_off;
            st_read_bias: line_cmd = lc_read_bias;
            st_read_wln: line_cmd = lc_wln_row_mid;
            st_read_sample: sample = 1'b1;
            st_read_wln_gnd: line_cmd = lc_wln_row_gnd;
            st_read_off: line_cmd = lc_all_off;
            st_compare: done = 1'b1;
            default: line_cmd = lc_none;
        endcase
    end

endmodule

// ==== source/cell_array_ctrl.sv ====
// controller top for one ferroelectric block; one command at a time over req/ack
`timescale 1ns/1ps
`include "cell_array_settings.svh"

module cell_array_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_req,
    output logic                    cmd_ack,
    input  cell_array_pkg::opcode_t opcode,
    input  cell_array_pkg::col_t    column,
    input  cell_array_pkg::word_t   data_in,
    output cell_array_pkg::word_t   data_out,
    output logic                    read_active,
    output logic                    verify_ok,
    output logic [2*`CELL_COLS-1:0] PL,
    output logic [`CELL_COLS-1:0]   BL,
    output logic [`CELL_ROWS-1:0]   WLN,
    output logic [`CELL_ROWS-1:0]   WLP,
    output logic                    PRG,
    input  logic                    sense,
    input  logic                    cell_written
);
    import cell_array_pkg::*;

    logic      start;
    logic      done;
    logic      sample;
    opcode_t   op;
    col_t      sel_col;
    word_t     word;
    line_cmd_t line_cmd;
    row_t      row;

    command_intake i_intake (
        .clk     (clk),
        .reset   (reset),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .opcode  (opcode),
        .column  (column),
        .data_in (data_in),
        .done    (done),
        .start   (start),
        .op      (op),
        .sel_col (sel_col),
        .word    (word)
    );

    array_sequencer i_sequencer (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .op           (op),
        .cell_written (cell_written),
        .word         (word),
        .line_cmd     (line_cmd),
        .row          (row),
        .sample       (sample),
        .read_active  (read_active),
        .done         (done)
    );

    line_driver i_driver (
        .clk      (clk),
        .reset    (reset),
        .line_cmd (line_cmd),
        .row      (row),
        .sel_col  (sel_col),
        .PL       (PL),
        .BL       (BL),
        .WLN      (WLN),
        .WLP      (WLP),
        .PRG      (PRG)
    );

    read_capture i_capture (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .sample    (sample),
        .row       (row),
        .sense     (sense),
        .word      (word),
        .data_out  (data_out),
        .verify_ok (verify_ok)
    );

endmodule

// ==== source/cell_array_pkg.sv ====
// shared types and level encodings; geometry comes from the settings header
`include "cell_array_settings.svh"

package cell_array_pkg;

    typedef logic [`CELL_ROWS-1:0] word_t;
    typedef logic [`CELL_ROW_W-1:0] row_t;
    typedef logic [`CELL_COL_W-1:0] col_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } opcode_t;

    // commands from the sequencer to the line registers
    typedef enum logic [3:0] {
        lc_none,
        lc_all_off,
        lc_wln_all_mid,
        lc_bias_unselected,
        lc_wln_all_gnd,
        lc_pl_sel_high,
        lc_wlp_row_high,
        lc_wln_row_mid,
        lc_wln_row_gnd,
        lc_wlp_row_mid,
        lc_sel_off,
        lc_read_bias
    } line_cmd_t;

    typedef enum logic [1:0] {
        pl_gnd  = 2'd0,
        pl_mid  = 2'd1,
        pl_read = 2'd2,
        pl_high = 2'd3
    } pl_level_t;

    // single-bit line levels, note WLN and WLP are inverted
    localparam logic bl_gnd    = 1'b0;
    localparam logic bl_mid    = 1'b1;
    localparam logic wln_mid   = 1'b0;
    localparam logic wln_gnd   = 1'b1;
    localparam logic wlp_high  = 1'b0;
    localparam logic wlp_mid   = 1'b1;
    localparam logic prg_read  = 1'b0;
    localparam logic prg_write = 1'b1;

    typedef enum logic [4:0] {
        st_idle,
        st_wln_all_mid,
        st_bias_unsel,
        st_wln_all_gnd,
        st_pl_sel_high,
        st_prg_write,
        st_scan,
        st_wlp_high,
        st_wln_mid,
        st_wait_written,
        st_wln_gnd,
        st_wlp_mid,
        st_sel_off,
        st_all_off,
        st_read_bias,
        st_read_wln,
        st_read_sample,
        st_read_wln_gnd,
        st_read_off,
        st_compare
    } seq_state_t;

endpackage

// ==== source/cell_array_settings.svh ====
// array geometry; CELL_ROWS and CELL_COLS must both be at least 2, widths are derived
`ifndef CELL_ARRAY_SETTINGS_SVH
`define CELL_ARRAY_SETTINGS_SVH

// rows per column, also the data word width
`define CELL_ROWS 8

// number of columns in the block
`define CELL_COLS 4

// index widths, never below one bit
`define CELL_ROW_W (($clog2(`CELL_ROWS) > 0) ? $clog2(`CELL_ROWS) : 1)
`define CELL_COL_W (($clog2(`CELL_COLS) > 0) ? $clog2(`CELL_COLS) : 1)

`endif

// ==== source/command_intake.sv ====
// four-phase req/ack intake; data_in must hold one value for two cycles before start
`timescale 1ns/1ps

module command_intake (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_req,
    output logic                   cmd_ack,
    input  cell_array_pkg::opcode_t opcode,
    input  cell_array_pkg::col_t    column,
    input  cell_array_pkg::word_t   data_in,
    input  logic                   done,
    output logic                   start,
    output cell_array_pkg::opcode_t op,
    output cell_array_pkg::col_t    sel_col,
    output cell_array_pkg::word_t   word
);
    import cell_array_pkg::*;

    logic  busy;
    logic  have_sample;
    logic  sampling;
    logic  agree;
    word_t prev_sample;

    // request pending, nothing running and no ack outstanding
    assign sampling = cmd_req && !busy && !cmd_ack;
    assign agree = have_sample && (data_in == prev_sample);

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_ack <= 1'b0;
            busy <= 1'b0;
            have_sample <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (done) begin
                busy <= 1'b0;
                cmd_ack <= 1'b1;
            end else if (cmd_ack && !cmd_req) begin
                // last phase of the handshake
                cmd_ack <= 1'b0;
            end else if (sampling) begin
                if (agree) begin
                    start <= 1'b1;
                    busy <= 1'b1;
                    have_sample <= 1'b0;
                end else begin
                    have_sample <= 1'b1;
                end
            end
        end
    end

    // command payload, frozen once the two samples agree
    always_ff @(posedge clk) begin
        if (sampling) begin
            prev_sample <= data_in;
        end
        if (sampling && agree) begin
            word <= data_in;
            op <= opcode;
            sel_col <= column;
        end
    end

endmodule

// ==== source/line_driver.sv ====
// registered array line levels; each command takes effect on the next clock edge
`timescale 1ns/1ps
`include "cell_array_settings.svh"

module line_driver (
    input  logic                      clk,
    input  logic                      reset,
    input  cell_array_pkg::line_cmd_t line_cmd,
    input  cell_array_pkg::row_t      row,
    input  cell_array_pkg::col_t      sel_col,
    output logic [2*`CELL_COLS-1:0]   PL,
    output logic [`CELL_COLS-1:0]     BL,
    output logic [`CELL_ROWS-1:0]     WLN,
    output logic [`CELL_ROWS-1:0]     WLP,
    output logic                      PRG
);
    import cell_array_pkg::*;

    always_ff @(posedge clk) begin
        if (reset || line_cmd == lc_all_off) begin
            PL <= {`CELL_COLS{pl_gnd}};
            BL <= {`CELL_COLS{bl_gnd}};
            WLN <= {`CELL_ROWS{wln_gnd}};
            WLP <= {`CELL_ROWS{wlp_mid}};
            PRG <= prg_read;
        end else begin
            case (line_cmd)
                lc_wln_all_mid: WLN <= {`CELL_ROWS{wln_mid}};
                lc_wln_all_gnd: WLN <= {`CELL_ROWS{wln_gnd}};
                lc_bias_unselected: begin
                    // half bias keeps unselected columns undisturbed
                    for (int c = 0; c < `CELL_COLS; c++) begin
                        if (col_t'(c) != sel_col) begin
                            BL[c] <= bl_mid;
                            PL[2*c +: 2] <= pl_mid;
                        end
                    end
                end
                lc_pl_sel_high: begin
                    PL[2*sel_col +: 2] <= pl_high;
                    PRG <= prg_write;
                end
                lc_wlp_row_high: WLP[row] <= wlp_high;
                lc_wln_row_mid: WLN[row] <= wln_mid;
                lc_wln_row_gnd: WLN[row] <= wln_gnd;
                lc_wlp_row_mid: WLP[row] <= wlp_mid;
                lc_sel_off: begin
                    PL[2*sel_col +: 2] <= pl_gnd;
                    BL[sel_col] <= bl_gnd;
                end
                lc_read_bias: begin
                    BL[sel_col] <= bl_mid;
                    PL[2*sel_col +: 2] <= pl_read;
                    PRG <= prg_read;
                end
                default: begin
                    // lc_none holds every line
                end
            endcase
        end
    end

endmodule

// ==== source/read_capture.sv ====
// sensed word assembly; verify_ok is only meaningful while cmd_ack is high after a write
`timescale 1ns/1ps

module read_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  sample,
    input  cell_array_pkg::row_t  row,
    input  logic                  sense,
    input  cell_array_pkg::word_t word,
    output cell_array_pkg::word_t data_out,
    output logic                  verify_ok
);
    import cell_array_pkg::*;

    word_t next_word;

    // captured word with the current sense bit merged in
    always_comb begin
        next_word = data_out;
        next_word[row] = sense;
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            data_out <= '0;
            verify_ok <= 1'b0;
        end else if (sample) begin
            data_out <= next_word;
            // final after the last row is sampled
            verify_ok <= (next_word == word);
        end
    end

endmodule

// ==== tests/cell_array_asserts.sv ====
// handshake and line safety checks on cell_array_ctrl, all disabled during reset
`timescale 1ns/1ps
`include "cell_array_settings.svh"

module cell_array_asserts (
    input logic                    clk,
    input logic                    reset,
    input logic                    cmd_req,
    input logic                    cmd_ack,
    input logic [2*`CELL_COLS-1:0] PL,
    input logic [`CELL_ROWS-1:0]   WLP,
    input logic                    PRG
);
    import cell_array_pkg::*;

    logic                  pl_high_seen;
    logic [`CELL_ROWS-1:0] wlp_high_rows;

    // one bit per row that has left wlp_mid
    assign wlp_high_rows = WLP ^ {`CELL_ROWS{wlp_mid}};

    always_comb begin
        pl_high_seen = 1'b0;
        for (int c = 0; c < `CELL_COLS; c++) begin
            if (PL[2*c +: 2] == pl_high) begin
                pl_high_seen = 1'b1;
            end
        end
    end

    ack_rises_with_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose while cmd_req was low");

    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
        $fell(cmd_ack) |-> !$past(cmd_req))
        else $error("cmd_ack fell while cmd_req was still high");

    single_wlp_high: assert property (@(posedge clk) disable iff (reset)
        $onehot0(wlp_high_rows))
        else $error("more than one WLP at wlp_high");

    wlp_high_needs_write: assert property (@(posedge clk) disable iff (reset)
        (|wlp_high_rows) |-> (PRG == prg_write))
        else $error("WLP at wlp_high while PRG is not prg_write");

    no_pl_high_in_read: assert property (@(posedge clk) disable iff (reset)
        !(pl_high_seen && PRG == prg_read))
        else $error("PL at pl_high while PRG is prg_read");

endmodule

bind cell_array_ctrl cell_array_asserts i_asserts (
    .clk     (clk),
    .reset   (reset),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .PL      (PL),
    .WLP     (WLP),
    .PRG     (PRG)
);

// ==== tests/cell_array_tb.sv ====
// random reads and writes, 200 commands; the cell model only sets bits, as the real cells do
`timescale 1ns/1ps
`include "cell_array_settings.svh"

module cell_array_tb;
    import cell_array_pkg::*;

    localparam int num_cmds = 200;
    localparam int max_cycles = num_cmds * 400;

    logic                    clk;
    logic                    reset;
    logic                    cmd_req;
    logic                    cmd_ack;
    opcode_t                 opcode;
    col_t                    column;
    word_t                   data_in;
    word_t                   data_out;
    logic                    read_active;
    logic                    verify_ok;
    logic [2*`CELL_COLS-1:0] PL;
    logic [`CELL_COLS-1:0]   BL;
    logic [`CELL_ROWS-1:0]   WLN;
    logic [`CELL_ROWS-1:0]   WLP;
    logic                    PRG;
    logic                    sense = 1'b0;
    logic                    cell_written = 1'b0;

    integer seed = 32'h3ec2;
    integer delay_seed = 32'h3ec2;
    int     cycles = 0;

    // cells as the line levels leave them, and the words the write rule predicts
    word_t  cells [`CELL_COLS] = '{default: '0};
    word_t  ref_words [`CELL_COLS] = '{default: '0};
    logic   prog_busy = 1'b0;
    row_t   prog_row = '0;
    int     wait_cnt = 0;

    cell_array_ctrl i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the commands did not finish within %0d clock cycles", max_cycles);
            $display("Test FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic int col_at_level(input pl_level_t level);
        int found;
        int c;
        found = -1;
        for (c = 0; c < `CELL_COLS; c++) begin
            if (PL[2*c +: 2] == level) begin
                found = c;
            end
        end
        return found;
    endfunction

    // row with WLN at mid, and WLP at high too when need_wlp is set
    function automatic int row_selected(input logic need_wlp);
        int found;
        int r;
        found = -1;
        for (r = 0; r < `CELL_ROWS; r++) begin
            if (WLN[r] == wln_mid && (!need_wlp || WLP[r] == wlp_high)) begin
                found = r;
            end
        end
        return found;
    endfunction

    task automatic step_model();
        int c;
        int r;
        c = col_at_level(pl_read);
        r = row_selected(1'b0);
        if (c >= 0 && r >= 0) begin
            sense = cells[c][r];
        end else begin
            sense = 1'b0;
        end
        c = col_at_level(pl_high);
        r = row_selected(1'b1);
        if (!prog_busy && PRG == prg_write && c >= 0 && r >= 0) begin
            cells[c][r] = 1'b1;
            prog_busy = 1'b1;
            prog_row = row_t'(r);
            wait_cnt = $unsigned($random(delay_seed)) % 6;
        end
        // write-done stays up until the row's WLN is back at ground
        if (prog_busy) begin
            if (WLN[prog_row] == wln_gnd) begin
                prog_busy = 1'b0;
                cell_written = 1'b0;
            end else if (wait_cnt == 0) begin
                cell_written = 1'b1;
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    endtask

    always @(posedge clk) begin
        #1;
        step_model();
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ack();
        do begin
            next_cycle();
        end while (cmd_ack !== 1'b1);
    endtask

    task automatic release_req();
        cmd_req = 1'b0;
        do begin
            next_cycle();
        end while (cmd_ack !== 1'b0);
    endtask

    task automatic check_idle_lines();
        check_value("PL", 32'(PL), 32'({`CELL_COLS{pl_gnd}}));
        check_value("BL", 32'(BL), 32'({`CELL_COLS{bl_gnd}}));
        check_value("WLN", 32'(WLN), 32'({`CELL_ROWS{wln_gnd}}));
        check_value("WLP", 32'(WLP), 32'({`CELL_ROWS{wlp_mid}}));
        check_value("PRG", 32'(PRG), 32'(prg_read));
    endtask

    task automatic run_read();
        col_t col;
        col = col_t'($unsigned($random(seed)) % `CELL_COLS);
        opcode = op_read;
        column = col;
        data_in = word_t'($random(seed));
        cmd_req = 1'b1;
        wait_ack();
        check_value("read data_out", 32'(data_out), 32'(ref_words[col]));
        check_value("read_active after read", 32'(read_active), 32'd1);
        check_value("cells after read", 32'(cells[col]), 32'(ref_words[col]));
        check_idle_lines();
        release_req();
    endtask

    task automatic run_write();
        col_t  col;
        word_t data;
        word_t noise;
        word_t expect_word;
        int    settle;
        int    i;
        col = col_t'($unsigned($random(seed)) % `CELL_COLS);
        // about half the writes only add bits, so their verify passes
        if ($random(seed) & 1) begin
            data = ref_words[col] | word_t'($random(seed));
        end else begin
            data = word_t'($random(seed));
        end
        settle = $unsigned($random(seed)) % 4;
        opcode = op_write;
        column = col;
        noise = word_t'($random(seed));
        data_in = noise;
        cmd_req = 1'b1;
        // bouncing data whose neighbours never match
        for (i = 0; i < settle; i++) begin
            next_cycle();
            noise = noise ^ (word_t'($random(seed)) | word_t'(1));
            data_in = noise;
        end
        next_cycle();
        data_in = data;
        wait_ack();
        expect_word = ref_words[col] | data;
        check_value("verify_ok after write", 32'(verify_ok), 32'(expect_word == data));
        check_value("read-back data_out", 32'(data_out), 32'(expect_word));
        check_value("cells after write", 32'(cells[col]), 32'(expect_word));
        check_value("read_active after write", 32'(read_active), 32'd0);
        check_idle_lines();
        ref_words[col] = expect_word;
        release_req();
    endtask

    initial begin
        int n;
        reset = 1'b1;
        cmd_req = 1'b0;
        opcode = op_read;
        column = '0;
        data_in = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        check_value("cmd_ack after reset", 32'(cmd_ack), 32'd0);
        check_value("read_active after reset", 32'(read_active), 32'd0);
        check_value("verify_ok after reset", 32'(verify_ok), 32'd0);
        check_idle_lines();
        for (n = 0; n < num_cmds; n++) begin
            if ($random(seed) & 1) begin
                run_write();
            end else begin
                run_read();
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/cell_array_pkg.sv
source/command_intake.sv
source/array_sequencer.sv
source/line_driver.sv
source/read_capture.sv
source/cell_array_ctrl.sv
tests/cell_array_asserts.sv
tests/cell_array_tb.sv
